//--- Makefile
TOP := radio_ctrl_core_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/1ps -f filelist.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Test passed$$" sim.log

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps -f filelist.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
hdl/ctrl_bus_pkg.sv
hdl/radio_regs_pkg.sv
hdl/wb_bus_if.sv
hdl/wb_region_decode.sv
hdl/misc_regs.sv
hdl/settings_bus.sv
hdl/time_keeper.sv
hdl/readback_regs.sv
hdl/radio_ctrl_core.sv
testbench/radio_ctrl_core_chk.sv
testbench/radio_ctrl_core_tb.sv

//--- hdl/ctrl_bus_pkg.sv
// Control bus package: Wishbone widths, region codes and address decode
`default_nettype none

package ctrl_bus_pkg;

   localparam int wb_dw = 16;                 // Data width
   localparam int wb_aw = 11;                 // Address width
   localparam int wb_sw = 2;                  // Byte selects

   typedef enum logic [1:0] {
      REGION_MISC,
      REGION_READBACK,
      REGION_SETTINGS,
      REGION_NONE
   } region_t;

   // Region field lives in address bits 10..7
   localparam int RGN_MSB = 10;
   localparam int RGN_LSB = 7;
   localparam int SET_BIT = 10;               // Any address with this bit set is a setting

   localparam logic [3:0] REGION_MISC_CODE     = 4'd0;
   localparam logic [3:0] REGION_READBACK_CODE = 4'd7;

   localparam logic [wb_dw-1:0] UNMAPPED_DATA = 16'h0000;

   function automatic region_t decode_region(input logic [wb_aw-1:0] adr);
      region_t rgn;
      if (adr[SET_BIT])
         rgn = REGION_SETTINGS;
      else if (adr[RGN_MSB:RGN_LSB] == REGION_MISC_CODE)
         rgn = REGION_MISC;
      else if (adr[RGN_MSB:RGN_LSB] == REGION_READBACK_CODE)
         rgn = REGION_READBACK;
      else
         rgn = REGION_NONE;
      return rgn;
   endfunction

endpackage

`default_nettype wire

//--- hdl/misc_regs.sv
// Misc registers: clock generator control and status plus a scratch word
`timescale 1ns/1ps
`default_nettype none

module misc_regs import ctrl_bus_pkg::*, radio_regs_pkg::*; (
   input  wire        wb_clk,
   input  wire        wb_rst,
   wb_bus_if.slave    bus,
   input  wire [2:0]  cgen_st_i,         // {status, ld, refmon}
   output logic       cgen_sync_b_o,
   output logic       cgen_ref_sel_o
);

   logic [wb_dw-1:0] cgen_ctrl_q;
   logic [wb_dw-1:0] test_q;
   logic [6:0]       offset;

   assign offset = {bus.adr[6:1], 1'b0};   // Byte lane bit dropped

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         cgen_ctrl_q <= 16'h0003;           // Sync deasserted, external ref
         test_q      <= '0;
      end
      else if (bus.cyc && bus.stb && bus.we)
      begin
         case (offset)
            REG_CGEN_CTRL: cgen_ctrl_q <= bus.dat_w;
            REG_TEST:      test_q      <= bus.dat_w;
            default:       ;
         endcase
      end
   end

   assign cgen_sync_b_o  = cgen_ctrl_q[1];
   assign cgen_ref_sel_o = cgen_ctrl_q[0];

   // Zero wait state slave
   assign bus.ack = bus.cyc & bus.stb;

   always_comb
   begin
      case (offset)
         REG_CGEN_CTRL: bus.dat_r = cgen_ctrl_q;
         REG_CGEN_ST:   bus.dat_r = {13'd0, cgen_st_i};
         REG_TEST:      bus.dat_r = test_q;
         default:       bus.dat_r = MISC_DEFAULT_DATA;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/radio_ctrl_core.sv
// Radio control core top, host Wishbone port to misc, settings, time and readback
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_core import ctrl_bus_pkg::*, radio_regs_pkg::*; (
   input  wire              wb_clk,
   input  wire              wb_rst,
   input  wire [wb_aw-1:0]  wb_adr_i,
   input  wire [wb_dw-1:0]  wb_dat_i,
   output wire [wb_dw-1:0]  wb_dat_o,
   input  wire [wb_sw-1:0]  wb_sel_i,
   input  wire              wb_we_i,
   input  wire              wb_cyc_i,
   input  wire              wb_stb_i,
   output wire              wb_ack_o,
   input  wire              cgen_st_status_i,
   input  wire              cgen_st_ld_i,
   input  wire              cgen_st_refmon_i,
   output wire              cgen_sync_b_o,
   output wire              cgen_ref_sel_o,
   input  wire              pps_i
);

   wire        set_stb;
   set_addr_t  set_addr;
   set_data_t  set_data;
   wire [63:0] vita_time;
   wire [63:0] vita_time_pps;

   wb_bus_if misc_bus ();
   wb_bus_if set_bus ();
   wb_bus_if rb_bus ();

   ////////////////////////////////////////
   // Host side
   wb_region_decode i_wb_region_decode (
      .wb_clk (wb_clk),
      .wb_rst (wb_rst),
      .adr_i  (wb_adr_i),
      .dat_i  (wb_dat_i),
      .sel_i  (wb_sel_i),
      .we_i   (wb_we_i),
      .cyc_i  (wb_cyc_i),
      .stb_i  (wb_stb_i),
      .dat_o  (wb_dat_o),
      .ack_o  (wb_ack_o),
      .misc_m (misc_bus.master),
      .set_m  (set_bus.master),
      .rb_m   (rb_bus.master)
   );

   misc_regs i_misc_regs (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .bus            (misc_bus.slave),
      .cgen_st_i      ({cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i}),
      .cgen_sync_b_o  (cgen_sync_b_o),
      .cgen_ref_sel_o (cgen_ref_sel_o)
   );

   // Settings bus and its consumers
   settings_bus i_settings_bus (
      .wb_clk     (wb_clk),
      .wb_rst     (wb_rst),
      .bus        (set_bus.slave),
      .set_stb_o  (set_stb),
      .set_addr_o (set_addr),
      .set_data_o (set_data)
   );

   time_keeper #(.base_addr(SR_TIME64)) i_time_keeper (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .set_stb_i       (set_stb),
      .set_addr_i      (set_addr),
      .set_data_i      (set_data),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_time_pps_o (vita_time_pps)
   );

   readback_regs #(.test_addr(SR_REG_TEST32)) i_readback_regs (
      .wb_clk          (wb_clk),
      .wb_rst          (wb_rst),
      .bus             (rb_bus.slave),
      .set_stb_i       (set_stb),
      .set_addr_i      (set_addr),
      .set_data_i      (set_data),
      .vita_time_i     (vita_time),
      .vita_time_pps_i (vita_time_pps)
   );

endmodule

`default_nettype wire

//--- hdl/radio_regs_pkg.sv
// Radio register map: setting numbers, misc offsets and readback words
`default_nettype none

package radio_regs_pkg;

   typedef logic [7:0]  set_addr_t;           // Setting number
   typedef logic [31:0] set_data_t;           // Setting word

   ////////////////////////////////////////
   // Settings bus addresses
   localparam set_addr_t SR_TIME64     = 8'd42;   // +0 high, +1 low, +2 control
   localparam set_addr_t SR_REG_TEST32 = 8'd60;

   ////////////////////////////////////////
   // Misc register offsets
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;

   localparam logic [15:0] MISC_DEFAULT_DATA = 16'hBEEF;

   ////////////////////////////////////////
   // Readback word indices
   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;
   localparam logic [3:0] RB_COMPAT  = 4'd6;

   // Bump when the register map changes, major in the high half
   localparam set_data_t COMPAT_NUM = {16'd9, 16'd2};

endpackage

`default_nettype wire

//--- hdl/readback_regs.sv
// Readback window, serves 32-bit status words to the host as 16-bit halves
`timescale 1ns/1ps
`default_nettype none

module readback_regs import ctrl_bus_pkg::*, radio_regs_pkg::*; #(
   parameter set_addr_t test_addr = SR_REG_TEST32
) (
   input  wire          wb_clk,
   input  wire          wb_rst,
   wb_bus_if.slave      bus,
   input  wire          set_stb_i,
   input  set_addr_t    set_addr_i,
   input  set_data_t    set_data_i,
   input  wire [63:0]   vita_time_i,
   input  wire [63:0]   vita_time_pps_i
);

   set_data_t        test32_q;            // Survives bus reset, host checks for a loaded FPGA
   set_data_t        word;
   logic             ack_q;
   logic [wb_dw-1:0] dat_q;

   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == test_addr))
         test32_q <= set_data_i;
   end

   ////////////////////////////////////////
   // Word select
   always_comb
   begin
      case (bus.adr[5:2])
         RB_TIME_HI: word = vita_time_i[63:32];
         RB_TIME_LO: word = vita_time_i[31:0];
         RB_PPS_HI:  word = vita_time_pps_i[63:32];
         RB_PPS_LO:  word = vita_time_pps_i[31:0];
         RB_TEST32:  word = test32_q;
         RB_COMPAT:  word = COMPAT_NUM;
         default:    word = '0;
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_q <= 1'b0;
      else
         ack_q <= bus.cyc & bus.stb & ~ack_q;
   end

   // Bit 1 picks the half, high half when set
   always_ff @(posedge wb_clk)
   begin
      dat_q <= bus.adr[1] ? word[31:16] : word[15:0];
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_q;

endmodule

`default_nettype wire

//--- hdl/settings_bus.sv
// Settings bus, joins two 16-bit host writes into one 32-bit setting strobe
`timescale 1ns/1ps
`default_nettype none

module settings_bus import ctrl_bus_pkg::*, radio_regs_pkg::*; (
   input  wire        wb_clk,
   input  wire        wb_rst,
   wb_bus_if.slave    bus,
   output logic       set_stb_o,
   output set_addr_t  set_addr_o,
   output set_data_t  set_data_o
);

   logic             ack_q;
   logic [wb_dw-1:0] low_q;              // Low half waiting for its partner
   logic             req;
   logic             wr_hi;

   assign req   = bus.cyc & bus.stb & ~ack_q;
   assign wr_hi = req & bus.we & bus.adr[1];

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         ack_q     <= 1'b0;
         set_stb_o <= 1'b0;
      end
      else
      begin
         ack_q     <= req;
         set_stb_o <= wr_hi;                // Lines up with the ack
      end
   end

   // Payload
   always_ff @(posedge wb_clk)
   begin
      if (req && bus.we && !bus.adr[1])
         low_q <= bus.dat_w;
      if (wr_hi)
      begin
         set_addr_o <= bus.adr[9:2];
         set_data_o <= {bus.dat_w, low_q};
      end
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = UNMAPPED_DATA;      // Write only region

endmodule

`default_nettype wire

//--- hdl/time_keeper.sv
// VITA time keeper, 64-bit counter with immediate or PPS timed load and PPS capture
`timescale 1ns/1ps
`default_nettype none

module time_keeper import radio_regs_pkg::*; #(
   parameter set_addr_t base_addr = SR_TIME64
) (
   input  wire          wb_clk,
   input  wire          wb_rst,
   input  wire          set_stb_i,
   input  set_addr_t    set_addr_i,
   input  set_data_t    set_data_i,
   input  wire          pps_i,
   output logic [63:0]  vita_time_o,
   output logic [63:0]  vita_time_pps_o
);

   localparam set_addr_t addr_hi   = base_addr;
   localparam set_addr_t addr_lo   = base_addr + 8'd1;
   localparam set_addr_t addr_ctrl = base_addr + 8'd2;

   set_data_t   time_hi_q;
   set_data_t   time_lo_q;
   logic [2:0]  pps_q;                    // Two sync stages then edge history
   logic        pps_edge;
   logic        armed_q;                  // Load waiting for next PPS
   logic        load_now;
   logic [63:0] time_next;

   assign pps_edge = pps_q[1] & ~pps_q[2];
   assign load_now = set_stb_i && (set_addr_i == addr_ctrl) && set_data_i[0];

   always_comb
   begin
      if (load_now || (armed_q && pps_edge))
         time_next = {time_hi_q, time_lo_q};
      else
         time_next = vita_time_o + 64'd1;
   end

   ////////////////////////////////////////
   // Pending time words
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == addr_hi))
         time_hi_q <= set_data_i;
      if (set_stb_i && (set_addr_i == addr_lo))
         time_lo_q <= set_data_i;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_q           <= '0;
         armed_q         <= 1'b0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         pps_q       <= {pps_q[1:0], pps_i};
         vita_time_o <= time_next;
         if (set_stb_i && (set_addr_i == addr_ctrl))
            armed_q <= ~set_data_i[0];     // Bit 0 clear means wait for PPS
         else if (pps_edge)
            armed_q <= 1'b0;
         if (pps_edge)
            vita_time_pps_o <= time_next;  // Time as of this edge, new value on a load
      end
   end

endmodule

`default_nettype wire

//--- hdl/wb_bus_if.sv
// Wishbone classic link between the region decoder and one slave
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if import ctrl_bus_pkg::*; ();

   logic [wb_aw-1:0] adr;
   logic [wb_dw-1:0] dat_w;        // Master to slave
   logic [wb_dw-1:0] dat_r;        // Slave to master
   logic [wb_sw-1:0] sel;
   logic             we;
   logic             cyc;
   logic             stb;
   logic             ack;

   modport master (output adr, dat_w, sel, we, cyc, stb, input dat_r, ack);
   modport slave  (input adr, dat_w, sel, we, cyc, stb, output dat_r, ack);

endinterface

`default_nettype wire

//--- hdl/wb_region_decode.sv
// Region decoder, steers host accesses to misc, settings or readback slaves
`timescale 1ns/1ps
`default_nettype none

module wb_region_decode import ctrl_bus_pkg::*; (
   input  wire               wb_clk,
   input  wire               wb_rst,
   input  wire [wb_aw-1:0]   adr_i,
   input  wire [wb_dw-1:0]   dat_i,
   input  wire [wb_sw-1:0]   sel_i,
   input  wire               we_i,
   input  wire               cyc_i,
   input  wire               stb_i,
   output logic [wb_dw-1:0]  dat_o,
   output logic              ack_o,
   wb_bus_if.master          misc_m,
   wb_bus_if.master          set_m,
   wb_bus_if.master          rb_m
);

   region_t region_now;
   region_t region_q;
   region_t region_sel;
   logic    in_cycle_q;                    // Access open and not yet acked

   assign region_now = decode_region(adr_i);
   assign region_sel = in_cycle_q ? region_q : region_now;   // Route held for slow slaves

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         in_cycle_q <= 1'b0;
      else
         in_cycle_q <= cyc_i & stb_i & ~ack_o;
      if (!in_cycle_q)
         region_q <= region_now;
   end

   ////////////////////////////////////////
   // Request fan-out
   assign misc_m.adr   = adr_i;
   assign misc_m.dat_w = dat_i;
   assign misc_m.sel   = sel_i;
   assign misc_m.we    = we_i;
   assign misc_m.cyc   = cyc_i & (region_sel == REGION_MISC);
   assign misc_m.stb   = stb_i & (region_sel == REGION_MISC);

   assign set_m.adr    = adr_i;
   assign set_m.dat_w  = dat_i;
   assign set_m.sel    = sel_i;
   assign set_m.we     = we_i;
   assign set_m.cyc    = cyc_i & (region_sel == REGION_SETTINGS);
   assign set_m.stb    = stb_i & (region_sel == REGION_SETTINGS);

   assign rb_m.adr     = adr_i;
   assign rb_m.dat_w   = dat_i;
   assign rb_m.sel     = sel_i;
   assign rb_m.we      = we_i;
   assign rb_m.cyc     = cyc_i & (region_sel == REGION_READBACK);
   assign rb_m.stb     = stb_i & (region_sel == REGION_READBACK);

   // Response mux
   always_comb
   begin
      case (region_sel)
         REGION_MISC:
         begin
            dat_o = misc_m.dat_r;
            ack_o = misc_m.ack;
         end
         REGION_SETTINGS:
         begin
            dat_o = set_m.dat_r;
            ack_o = set_m.ack;
         end
         REGION_READBACK:
         begin
            dat_o = rb_m.dat_r;
            ack_o = rb_m.ack;
         end
         default:
         begin
            // Nobody home, answer at once so the host never hangs
            dat_o = UNMAPPED_DATA;
            ack_o = cyc_i & stb_i;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- testbench/radio_ctrl_core_chk.sv
// Wishbone handshake and reset checks, bound into the radio control core
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_core_chk (
   input wire wb_clk,
   input wire wb_rst,
   input wire wb_cyc_i,
   input wire wb_stb_i,
   input wire wb_ack_i,
   input wire cgen_sync_b_i
);

   // Ack only inside an open strobe
   ack_inside_cycle: assert property (@(posedge wb_clk) wb_ack_i |-> (wb_cyc_i && wb_stb_i))
      else $error("ack seen without cyc and stb");

   ack_low_in_reset: assert property (@(posedge wb_clk) wb_rst |-> !wb_ack_i)
      else $error("ack high during reset");

   sync_b_after_reset: assert property (@(posedge wb_clk) wb_rst |=> cgen_sync_b_i)
      else $error("cgen_sync_b low in the cycle after reset");

endmodule

bind radio_ctrl_core radio_ctrl_core_chk i_radio_ctrl_core_chk (
   .wb_clk        (wb_clk),
   .wb_rst        (wb_rst),
   .wb_cyc_i      (wb_cyc_i),
   .wb_stb_i      (wb_stb_i),
   .wb_ack_i      (wb_ack_o),
   .cgen_sync_b_i (cgen_sync_b_o)
);

`default_nettype wire

//--- testbench/radio_ctrl_core_tb.sv
// Directed testbench that drives the radio control core over its host Wishbone port
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_core_tb import ctrl_bus_pkg::*, radio_regs_pkg::*; ();

   localparam int        ack_timeout   = 32;              // Cycles allowed per access
   localparam set_addr_t set_time_hi   = SR_TIME64;
   localparam set_addr_t set_time_lo   = SR_TIME64 + 8'd1;
   localparam set_addr_t set_time_ctrl = SR_TIME64 + 8'd2;

   logic             wb_clk = 1'b0;
   logic             wb_rst;
   logic [wb_aw-1:0] wb_adr;
   logic [wb_dw-1:0] wb_dat_w;
   wire  [wb_dw-1:0] wb_dat_r;
   logic [wb_sw-1:0] wb_sel;
   logic             wb_we;
   logic             wb_cyc;
   logic             wb_stb;
   wire              wb_ack;
   logic             cgen_st_status;
   logic             cgen_st_ld;
   logic             cgen_st_refmon;
   wire              cgen_sync_b;
   wire              cgen_ref_sel;
   logic             pps;

   int unsigned error_count    = 0;
   int unsigned timeout_count  = 0;
   logic [31:0] rng_state      = 32'd85059;
   logic [31:0] time_hi_loaded = '0;           // High word of the last immediate load

   always #4 wb_clk = ~wb_clk;   // 8 ns period

   radio_ctrl_core i_radio_ctrl_core (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .wb_adr_i         (wb_adr),
      .wb_dat_i         (wb_dat_w),
      .wb_dat_o         (wb_dat_r),
      .wb_sel_i         (wb_sel),
      .wb_we_i          (wb_we),
      .wb_cyc_i         (wb_cyc),
      .wb_stb_i         (wb_stb),
      .wb_ack_o         (wb_ack),
      .cgen_st_status_i (cgen_st_status),
      .cgen_st_ld_i     (cgen_st_ld),
      .cgen_st_refmon_i (cgen_st_refmon),
      .cgen_sync_b_o    (cgen_sync_b),
      .cgen_ref_sel_o   (cgen_ref_sel),
      .pps_i            (pps)
   );

   ////////////////////////////////////////
   // Helpers
   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [wb_aw-1:0] misc_adr(input logic [6:0] offset);
      return {4'd0, offset};
   endfunction

   function automatic logic [wb_aw-1:0] set_adr(input set_addr_t num, input logic hi);
      return {1'b1, num, hi, 1'b0};           // Bit 1 set sends the strobe
   endfunction

   function automatic logic [wb_aw-1:0] rb_adr(input logic [3:0] word, input logic hi);
      return {4'd7, 1'b0, word, hi, 1'b0};
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("FAIL at time %0t: %s got %h expected %h", $time, name, got, exp);
      error_count++;
   endtask

   // Wait for ack, then close the cycle on the next rising edge
   task automatic wait_for_ack(input logic [wb_aw-1:0] adr, output logic [wb_dw-1:0] data);
      int   waited;
      logic got_ack;
      waited  = 0;
      got_ack = 1'b0;
      data    = '0;
      while (!got_ack && waited < ack_timeout)
      begin
         @(negedge wb_clk);
         if (wb_ack === 1'b1)
         begin
            got_ack = 1'b1;
            data    = wb_dat_r;
         end
         else
            waited++;
      end
      if (!got_ack)
      begin
         $display("No ack from the DUT within %0d cycles for address %h", ack_timeout, adr);
         timeout_count++;
      end
      @(posedge wb_clk);                      // Cycle ends on this edge
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input logic [wb_aw-1:0] adr, input logic [wb_dw-1:0] dat);
      logic [wb_dw-1:0] unused_rd;
      @(posedge wb_clk);
      wb_adr   <= adr;
      wb_dat_w <= dat;
      wb_sel   <= 2'b11;
      wb_we    <= 1'b1;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wait_for_ack(adr, unused_rd);
   endtask

   task automatic wb_read(input logic [wb_aw-1:0] adr, output logic [wb_dw-1:0] data);
      @(posedge wb_clk);
      wb_adr <= adr;
      wb_sel <= 2'b11;
      wb_we  <= 1'b0;
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wait_for_ack(adr, data);
   endtask

   task automatic write_setting(input set_addr_t num, input logic [31:0] data);
      wb_write(set_adr(num, 1'b0), data[15:0]);
      wb_write(set_adr(num, 1'b1), data[31:16]);
   endtask

   task automatic read_word(input logic [3:0] word, output logic [31:0] data);
      logic [15:0] lo;
      logic [15:0] hi;
      wb_read(rb_adr(word, 1'b0), lo);
      wb_read(rb_adr(word, 1'b1), hi);
      data = {hi, lo};
   endtask

   task automatic pulse_reset();
      @(posedge wb_clk);
      wb_rst <= 1'b1;
      repeat (4) @(posedge wb_clk);
      wb_rst <= 1'b0;
   endtask

   ////////////////////////////////////////
   // Directed tests
   task automatic test_reset_values();
      logic [15:0] rd;
      if (cgen_sync_b !== 1'b1)
         report_mismatch("cgen_sync_b_o", 64'(cgen_sync_b), 64'd1);
      if (cgen_ref_sel !== 1'b1)
         report_mismatch("cgen_ref_sel_o", 64'(cgen_ref_sel), 64'd1);
      wb_read(misc_adr(7'd4), rd);
      if (rd !== 16'h0003)
         report_mismatch("cgen_ctrl", 64'(rd), 64'h0003);
      wb_read(misc_adr(7'd0), rd);
      if (rd !== 16'hBEEF)
         report_mismatch("misc offset 0", 64'(rd), 64'hBEEF);
   endtask

   task automatic test_misc_regs();
      logic [31:0] rnd;
      logic [15:0] val_test;
      logic [15:0] val_ctrl;
      logic [15:0] rd;
      rnd      = next_random();
      val_test = rnd[15:0];
      val_ctrl = rnd[31:16];
      wb_write(misc_adr(7'd8), val_test);
      wb_write(misc_adr(7'd4), val_ctrl);
      wb_read(misc_adr(7'd8), rd);
      if (rd !== val_test)
         report_mismatch("misc test register", 64'(rd), 64'(val_test));
      wb_read(misc_adr(7'd4), rd);
      if (rd !== val_ctrl)
         report_mismatch("cgen_ctrl", 64'(rd), 64'(val_ctrl));
      if (cgen_sync_b !== val_ctrl[1])
         report_mismatch("cgen_sync_b_o", 64'(cgen_sync_b), 64'(val_ctrl[1]));
      if (cgen_ref_sel !== val_ctrl[0])
         report_mismatch("cgen_ref_sel_o", 64'(cgen_ref_sel), 64'(val_ctrl[0]));
      rnd = next_random();
      @(posedge wb_clk);
      cgen_st_status <= rnd[2];
      cgen_st_ld     <= rnd[1];
      cgen_st_refmon <= rnd[0];
      wb_read(misc_adr(7'd6), rd);
      if (rd !== {13'd0, rnd[2:0]})
         report_mismatch("cgen_status", 64'(rd), 64'(rnd[2:0]));
   endtask

   task automatic test_settings_test32();
      logic [31:0] val;
      logic [31:0] rd;
      val = next_random();
      write_setting(SR_REG_TEST32, val);
      read_word(4'd4, rd);
      if (rd !== val)
         report_mismatch("test32", 64'(rd), 64'(val));
      pulse_reset();                          // Register must keep its value
      read_word(4'd4, rd);
      if (rd !== val)
         report_mismatch("test32 after reset", 64'(rd), 64'(val));
      read_word(4'd6, rd);
      if (rd !== 32'h0009_0002)
         report_mismatch("compat number", 64'(rd), 64'h0009_0002);
   endtask

   task automatic test_time_load();
      logic [31:0] hi_word;
      logic [31:0] rd;
      hi_word = next_random();
      write_setting(set_time_hi, hi_word);
      write_setting(set_time_lo, 32'd0);
      write_setting(set_time_ctrl, 32'd1);    // Bit 0 set loads at once
      time_hi_loaded = hi_word;
      read_word(4'd0, rd);
      if (rd !== hi_word)
         report_mismatch("vita time high", 64'(rd), 64'(hi_word));
      read_word(4'd1, rd);
      if ($isunknown(rd) || rd == 32'd0 || rd >= 32'd200)
      begin
         $display("FAIL at time %0t: vita time low got %h expected 1 to 199", $time, rd);
         error_count++;
      end
   endtask

   task automatic test_pps_load();
      logic [31:0] hi2;
      logic [31:0] rd;
      hi2 = next_random();
      if (hi2 == time_hi_loaded)
         hi2 = ~time_hi_loaded;               // Must differ from the running high word
      write_setting(set_time_hi, hi2);
      write_setting(set_time_lo, 32'd0);
      write_setting(set_time_ctrl, 32'd0);    // Armed for next PPS
      repeat (20) @(posedge wb_clk);
      read_word(4'd0, rd);
      if ($isunknown(rd) || rd === hi2)
      begin
         $display("FAIL at time %0t: vita time high got %h expected other than %h before PPS",
                  $time, rd, hi2);
         error_count++;
      end
      @(posedge wb_clk);
      pps <= 1'b1;
      repeat (6) @(posedge wb_clk);           // Two sync stages plus edge detect
      pps <= 1'b0;
      read_word(4'd0, rd);
      if (rd !== hi2)
         report_mismatch("vita time high", 64'(rd), 64'(hi2));
      read_word(4'd2, rd);
      if (rd !== hi2)
         report_mismatch("pps time high", 64'(rd), 64'(hi2));
      read_word(4'd3, rd);
      if ($isunknown(rd) || rd >= 32'd10)
      begin
         $display("FAIL at time %0t: pps time low got %h expected below 10", $time, rd);
         error_count++;
      end
   endtask

   task automatic test_unmapped();
      logic [15:0] rd;
      wb_read({4'd3, 7'd0}, rd);
      if (rd !== 16'h0000)
         report_mismatch("unmapped read", 64'(rd), 64'h0000);
   endtask

   ////////////////////////////////////////
   // Sequence
   initial
   begin
      wb_rst         <= 1'b1;
      wb_adr         <= '0;
      wb_dat_w       <= '0;
      wb_sel         <= '0;
      wb_we          <= 1'b0;
      wb_cyc         <= 1'b0;
      wb_stb         <= 1'b0;
      cgen_st_status <= 1'b0;
      cgen_st_ld     <= 1'b0;
      cgen_st_refmon <= 1'b0;
      pps            <= 1'b0;
      repeat (4) @(posedge wb_clk);
      wb_rst <= 1'b0;
      test_reset_values();
      test_misc_regs();
      test_settings_test32();
      test_time_load();
      test_pps_load();
      test_unmapped();
      $display("Done: %0d errors, %0d timeouts", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
